// ==== source/uart_pkg.sv ====
package uart_pkg;

  // Bus and buffer sizing
  localparam int addr_width = 5;
  localparam int fifo_depth = 8;
  localparam int level_width = 4;
  localparam int cnt_width = 3;

  // Roughly 115200 baud from a 10 MHz clock
  localparam logic [15:0] div_reset = 16'd85;

  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Register opcodes, reg_none for anything unmapped
  typedef enum logic [2:0] {
    reg_txdata,
    reg_rxdata,
    reg_txctrl,
    reg_rxctrl,
    reg_ie,
    reg_ip,
    reg_div,
    reg_none
  } uart_reg_e;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_e;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

endpackage

// ==== source/uart_axil_front.sv ====
`timescale 1ns/10ps

module uart_axil_front (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [uart_pkg::addr_width-1:0] s_awaddr,
  input  logic                            s_awvalid,
  output logic                            s_awready,
  input  logic [31:0]                     s_wdata,
  input  logic [3:0]                      s_wstrb,
  input  logic                            s_wvalid,
  output logic                            s_wready,
  output logic [1:0]                      s_bresp,
  output logic                            s_bvalid,
  input  logic                            s_bready,
  input  logic [uart_pkg::addr_width-1:0] s_araddr,
  input  logic                            s_arvalid,
  output logic                            s_arready,
  output logic [31:0]                     s_rdata,
  output logic [1:0]                      s_rresp,
  output logic                            s_rvalid,
  input  logic                            s_rready,
  output logic                            wr_en,
  output uart_pkg::uart_reg_e             wr_op,
  output logic [31:0]                     wr_data,
  output logic                            rd_en,
  output uart_pkg::uart_reg_e             rd_op,
  input  logic [31:0]                     rd_data
);
  import uart_pkg::*;

  function automatic uart_reg_e decode(input logic [addr_width-1:0] addr);
    uart_reg_e op;
    if (addr[1:0] != 2'b00) begin
      op = reg_none;
    end else begin
      case (addr[addr_width-1:2])
        3'd0: op = reg_txdata;
        3'd1: op = reg_rxdata;
        3'd2: op = reg_txctrl;
        3'd3: op = reg_rxctrl;
        3'd4: op = reg_ie;
        3'd5: op = reg_ip;
        3'd6: op = reg_div;
        default: op = reg_none;
      endcase
    end
    return op;
  endfunction

  // Both write halves go in the same cycle
  assign s_awready = !s_bvalid && (s_wvalid || !s_awvalid);
  assign s_wready = !s_bvalid && (s_awvalid || !s_wvalid);
  assign s_arready = !s_rvalid;

  assign wr_en = s_awvalid && s_wvalid && !s_bvalid;
  assign wr_op = decode(s_awaddr);
  // Byte strobes ignored, writes are full words
  assign wr_data = s_wdata;

  assign rd_en = s_arvalid && !s_rvalid;
  assign rd_op = decode(s_araddr);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      s_bvalid <= 1'b0;
      s_bresp <= resp_okay;
    end else if (wr_en) begin
      s_bvalid <= 1'b1;
      s_bresp <= (wr_op == reg_none) ? resp_slverr : resp_okay;
    end else if (s_bready) begin
      s_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      s_rvalid <= 1'b0;
      s_rresp <= resp_okay;
    end else if (rd_en) begin
      s_rvalid <= 1'b1;
      s_rresp <= (rd_op == reg_none) ? resp_slverr : resp_okay;
    end else if (s_rready) begin
      s_rvalid <= 1'b0;
    end
  end

  // Read data captured at acceptance
  always_ff @(posedge clock) begin
    if (rd_en) begin
      s_rdata <= rd_data;
    end
  end

  bvalid_hold_a: assert property (@(posedge clock) disable iff (reset)
    s_bvalid && !s_bready |=> s_bvalid);

  rvalid_hold_a: assert property (@(posedge clock) disable iff (reset)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata));

endmodule

// ==== source/uart_reg_bank.sv ====
`timescale 1ns/10ps

module uart_reg_bank (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             wr_en,
  input  uart_pkg::uart_reg_e              wr_op,
  input  logic [31:0]                      wr_data,
  input  logic                             rd_en,
  input  uart_pkg::uart_reg_e              rd_op,
  input  logic [uart_pkg::level_width-1:0] tx_level,
  input  logic [uart_pkg::level_width-1:0] rx_level,
  input  logic [7:0]                       rx_byte,
  output logic [31:0]                      rd_data,
  output logic                             tx_push,
  output logic [7:0]                       tx_byte,
  output logic                             rx_pop,
  output logic                             txen,
  output logic                             nstop,
  output logic                             rxen,
  output logic [15:0]                      div,
  output logic                             irq
);
  import uart_pkg::*;

  logic [cnt_width-1:0] txcnt;
  logic [cnt_width-1:0] rxcnt;
  logic ie_txwm;
  logic ie_rxwm;
  logic ip_txwm;
  logic ip_rxwm;
  logic tx_full;
  logic rx_empty;

  assign tx_full = tx_level == level_width'(fifo_depth);
  assign rx_empty = rx_level == '0;

  // Watermark pending bits follow the levels directly
  assign ip_txwm = tx_level < level_width'(txcnt);
  assign ip_rxwm = rx_level > level_width'(rxcnt);
  assign irq = (ip_txwm && ie_txwm) || (ip_rxwm && ie_rxwm);

  assign tx_push = wr_en && wr_op == reg_txdata && !tx_full;
  assign tx_byte = wr_data[7:0];
  assign rx_pop = rd_en && rd_op == reg_rxdata && !rx_empty;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      txen <= 1'b0;
      nstop <= 1'b0;
      txcnt <= '0;
      rxen <= 1'b0;
      rxcnt <= '0;
      ie_txwm <= 1'b0;
      ie_rxwm <= 1'b0;
      div <= div_reset;
    end else if (wr_en) begin
      case (wr_op)
        reg_txctrl: begin
          txen <= wr_data[0];
          nstop <= wr_data[1];
          txcnt <= wr_data[18:16];
        end
        reg_rxctrl: begin
          rxen <= wr_data[0];
          rxcnt <= wr_data[18:16];
        end
        reg_ie: begin
          ie_txwm <= wr_data[0];
          ie_rxwm <= wr_data[1];
        end
        reg_div: div <= wr_data[15:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (rd_op)
      reg_txdata: rd_data = {tx_full, 31'd0};
      // Byte field only valid when not empty
      reg_rxdata: rd_data = rx_empty ? {1'b1, 31'd0} : {24'd0, rx_byte};
      reg_txctrl: rd_data = {13'd0, txcnt, 14'd0, nstop, txen};
      reg_rxctrl: rd_data = {13'd0, rxcnt, 15'd0, rxen};
      reg_ie: rd_data = {30'd0, ie_rxwm, ie_txwm};
      reg_ip: rd_data = {30'd0, ip_rxwm, ip_txwm};
      reg_div: rd_data = {16'd0, div};
      default: rd_data = 32'd0;
    endcase
  end

  // A push into a full FIFO would carry the level past the depth
  tx_push_room_a: assert property (@(posedge clock) disable iff (reset)
    tx_level <= level_width'(fifo_depth));

endmodule

// ==== source/uart_fifo.sv ====
`timescale 1ns/10ps

module uart_fifo (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             push,
  input  logic [7:0]                       push_data,
  input  logic                             pop,
  output logic [7:0]                       pop_data,
  output logic [uart_pkg::level_width-1:0] level
);
  import uart_pkg::*;

  logic [7:0] mem [fifo_depth];
  logic [$clog2(fifo_depth)-1:0] wr_ptr;
  logic [$clog2(fifo_depth)-1:0] rd_ptr;

  // Head entry visible without a pop
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        level <= level + 1'b1;
      end else if (pop && !push) begin
        level <= level - 1'b1;
      end
    end
  end

  fifo_bounds_a: assert property (@(posedge clock) disable iff (reset)
    !(push && !pop && level == level_width'(fifo_depth)) && !(pop && level == '0));

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             txen,
  input  logic                             nstop,
  input  logic [15:0]                      div,
  input  logic [uart_pkg::level_width-1:0] fifo_level,
  input  logic [7:0]                       fifo_data,
  output logic                             fifo_pop,
  output logic                             tx
);
  import uart_pkg::*;

  tx_state_e state;
  logic [15:0] baud_cnt;
  logic [2:0] bit_cnt;
  logic [7:0] shift;
  logic bit_end;

  // Each bit lasts div+1 cycles
  assign bit_end = baud_cnt >= div;
  assign fifo_pop = state == tx_idle && txen && fifo_level != '0;

  assign tx = (state == tx_start) ? 1'b0 : (state == tx_data) ? shift[0] : 1'b1;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= tx_idle;
      baud_cnt <= '0;
      bit_cnt <= '0;
    end else if (state == tx_idle) begin
      baud_cnt <= '0;
      bit_cnt <= '0;
      if (fifo_pop) begin
        state <= tx_start;
      end
    end else if (!bit_end) begin
      baud_cnt <= baud_cnt + 16'd1;
    end else begin
      baud_cnt <= '0;
      case (state)
        tx_start: state <= tx_data;
        tx_data: begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            state <= tx_stop;
          end
        end
        tx_stop: begin
          // bit_cnt marks the second stop bit
          if (nstop && bit_cnt == 3'd0) begin
            bit_cnt <= 3'd1;
          end else begin
            state <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // LSB first
  always_ff @(posedge clock) begin
    if (fifo_pop) begin
      shift <= fifo_data;
    end else if (state == tx_data && bit_end) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             rxen,
  input  logic [15:0]                      div,
  input  logic                             rx,
  input  logic [uart_pkg::level_width-1:0] fifo_level,
  output logic                             fifo_push,
  output logic [7:0]                       fifo_data
);
  import uart_pkg::*;

  rx_state_e state;
  logic rx_meta;
  logic rx_sync;
  logic rx_last;
  logic [15:0] baud_cnt;
  logic [15:0] half_point;
  logic [2:0] bit_cnt;
  logic [7:0] shift;
  logic bit_end;

  // Line idles high
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  // Half a bit to reach the middle of the start bit
  assign half_point = {1'b0, div[15:1]};
  assign bit_end = (state == rx_start) ? (baud_cnt >= half_point) : (baud_cnt >= div);

  // Bad stop bit or full FIFO drops the byte
  assign fifo_push = state == rx_stop && bit_end && rx_sync && rxen &&
                     fifo_level != level_width'(fifo_depth);
  assign fifo_data = shift;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= rx_idle;
      baud_cnt <= '0;
      bit_cnt <= '0;
    end else if (state == rx_idle) begin
      baud_cnt <= '0;
      bit_cnt <= '0;
      if (rxen && rx_last && !rx_sync) begin
        state <= rx_start;
      end
    end else if (!bit_end) begin
      baud_cnt <= baud_cnt + 16'd1;
    end else begin
      baud_cnt <= '0;
      case (state)
        // Glitch, not a start bit
        rx_start: state <= rx_sync ? rx_idle : rx_data;
        rx_data: begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            state <= rx_stop;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == rx_data && bit_end) begin
      shift <= {rx_sync, shift[7:1]};
    end
  end

endmodule

// ==== source/uart_top.sv ====
`timescale 1ns/10ps

module uart_top (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [uart_pkg::addr_width-1:0] s_awaddr,
  input  logic                            s_awvalid,
  output logic                            s_awready,
  input  logic [31:0]                     s_wdata,
  input  logic [3:0]                      s_wstrb,
  input  logic                            s_wvalid,
  output logic                            s_wready,
  output logic [1:0]                      s_bresp,
  output logic                            s_bvalid,
  input  logic                            s_bready,
  input  logic [uart_pkg::addr_width-1:0] s_araddr,
  input  logic                            s_arvalid,
  output logic                            s_arready,
  output logic [31:0]                     s_rdata,
  output logic [1:0]                      s_rresp,
  output logic                            s_rvalid,
  input  logic                            s_rready,
  output logic                            tx,
  input  logic                            rx,
  output logic                            irq
);
  import uart_pkg::*;

  logic wr_en;
  logic rd_en;
  uart_reg_e wr_op;
  uart_reg_e rd_op;
  logic [31:0] wr_data;
  logic [31:0] rd_data;
  logic tx_push;
  logic tx_pop;
  logic rx_push;
  logic rx_pop;
  logic [7:0] tx_byte;
  logic [7:0] tx_head;
  logic [7:0] rx_byte;
  logic [7:0] rx_head;
  logic [level_width-1:0] tx_level;
  logic [level_width-1:0] rx_level;
  logic txen;
  logic nstop;
  logic rxen;
  logic [15:0] div;

  uart_axil_front front0 (
    .clock(clock), .reset(reset),
    .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
    .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
    .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
    .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
    .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
    .wr_en(wr_en), .wr_op(wr_op), .wr_data(wr_data),
    .rd_en(rd_en), .rd_op(rd_op), .rd_data(rd_data)
  );

  uart_reg_bank bank0 (
    .clock(clock), .reset(reset),
    .wr_en(wr_en), .wr_op(wr_op), .wr_data(wr_data),
    .rd_en(rd_en), .rd_op(rd_op),
    .tx_level(tx_level), .rx_level(rx_level), .rx_byte(rx_head),
    .rd_data(rd_data), .tx_push(tx_push), .tx_byte(tx_byte), .rx_pop(rx_pop),
    .txen(txen), .nstop(nstop), .rxen(rxen), .div(div), .irq(irq)
  );

  uart_fifo tx_fifo0 (
    .clock(clock), .reset(reset),
    .push(tx_push), .push_data(tx_byte), .pop(tx_pop),
    .pop_data(tx_head), .level(tx_level)
  );

  uart_fifo rx_fifo0 (
    .clock(clock), .reset(reset),
    .push(rx_push), .push_data(rx_byte), .pop(rx_pop),
    .pop_data(rx_head), .level(rx_level)
  );

  uart_tx tx0 (
    .clock(clock), .reset(reset),
    .txen(txen), .nstop(nstop), .div(div),
    .fifo_level(tx_level), .fifo_data(tx_head),
    .fifo_pop(tx_pop), .tx(tx)
  );

  uart_rx rx0 (
    .clock(clock), .reset(reset),
    .rxen(rxen), .div(div), .rx(rx), .fifo_level(rx_level),
    .fifo_push(rx_push), .fifo_data(rx_byte)
  );

endmodule

// ==== tb/uart_tb.sv ====
`timescale 1ns/10ps

module uart_tb;
  import uart_pkg::*;

  localparam int wait_limit = 2000;
  localparam int poll_limit = 300;

  // Shadow of the register bank and the FIFO levels
  typedef struct packed {
    logic txen;
    logic nstop;
    logic [cnt_width-1:0] txcnt;
    logic rxen;
    logic [cnt_width-1:0] rxcnt;
    logic [1:0] ie;
    logic [15:0] div;
    logic [level_width-1:0] tx_level;
    logic [level_width-1:0] rx_level;
    logic [7:0] rx_head;
  } model_t;

  logic clock;
  logic reset;
  logic [addr_width-1:0] s_awaddr;
  logic s_awvalid;
  logic s_awready;
  logic [31:0] s_wdata;
  logic [3:0] s_wstrb;
  logic s_wvalid;
  logic s_wready;
  logic [1:0] s_bresp;
  logic s_bvalid;
  logic s_bready;
  logic [addr_width-1:0] s_araddr;
  logic s_arvalid;
  logic s_arready;
  logic [31:0] s_rdata;
  logic [1:0] s_rresp;
  logic s_rvalid;
  logic s_rready;
  logic line;
  logic irq;

  model_t model;
  logic [7:0] sent_q [$];
  logic [addr_width-1:0] bad_addr [7] = '{5'h1c, 5'h1d, 5'h1e, 5'h1f, 5'h01, 5'h0a, 5'h16};
  int data_errors = 0;
  int resp_errors = 0;
  int irq_errors = 0;
  int timeouts = 0;

  // Loopback through the serial line
  uart_top dut0 (
    .clock(clock), .reset(reset),
    .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
    .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
    .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
    .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
    .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
    .tx(line), .rx(line), .irq(irq)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [addr_width-1:0] offset_of(input uart_reg_e op);
    case (op)
      reg_txdata: return 5'h00;
      reg_rxdata: return 5'h04;
      reg_txctrl: return 5'h08;
      reg_rxctrl: return 5'h0c;
      reg_ie: return 5'h10;
      reg_ip: return 5'h14;
      reg_div: return 5'h18;
      default: return 5'h1c;
    endcase
  endfunction

  function automatic logic [31:0] exp_read(input uart_reg_e op, input model_t m);
    logic [31:0] word;
    word = 32'd0;
    case (op)
      reg_txdata: word[31] = m.tx_level == level_width'(fifo_depth);
      reg_rxdata: begin
        if (m.rx_level == '0) begin
          word[31] = 1'b1;
        end else begin
          word[7:0] = m.rx_head;
        end
      end
      reg_txctrl: begin
        word[0] = m.txen;
        word[1] = m.nstop;
        word[18:16] = m.txcnt;
      end
      reg_rxctrl: begin
        word[0] = m.rxen;
        word[18:16] = m.rxcnt;
      end
      reg_ie: word[1:0] = m.ie;
      reg_ip: begin
        word[0] = m.tx_level < level_width'(m.txcnt);
        word[1] = m.rx_level > level_width'(m.rxcnt);
      end
      reg_div: word[15:0] = m.div;
      default: word = 32'd0;
    endcase
    return word;
  endfunction

  function automatic logic exp_irq(input model_t m);
    logic [31:0] ip;
    ip = exp_read(reg_ip, m);
    return |(ip[1:0] & m.ie);
  endfunction

  function automatic void model_write(input uart_reg_e op, input logic [31:0] data);
    case (op)
      reg_txdata: begin
        // Level not tracked while the transmitter drains the FIFO
        if (model.txen) begin
          sent_q.push_back(data[7:0]);
        end else if (model.tx_level != level_width'(fifo_depth)) begin
          model.tx_level = model.tx_level + level_width'(1);
          sent_q.push_back(data[7:0]);
        end
      end
      reg_txctrl: begin
        model.txen = data[0];
        model.nstop = data[1];
        model.txcnt = data[18:16];
      end
      reg_rxctrl: begin
        model.rxen = data[0];
        model.rxcnt = data[18:16];
      end
      reg_ie: model.ie = data[1:0];
      reg_div: model.div = data[15:0];
      default: ;
    endcase
  endfunction

  task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      data_errors++;
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      resp_errors++;
    end
  endtask

  task automatic check_irq(input logic exp);
    if (irq !== exp) begin
      $display("Error at %0t ns: irq is %b, expected %b", $time, irq, exp);
      irq_errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    timeouts++;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (3) @(negedge clock);
    reset = 1'b0;
    model = '0;
    model.div = div_reset;
    sent_q.delete();
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic axi_write(input logic [addr_width-1:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    s_awaddr = addr;
    s_wdata = data;
    s_wstrb = 4'hf;
    s_awvalid = 1'b1;
    s_wvalid = 1'b1;
    n = 0;
    #1;
    while (!(s_awready && s_wready) && n < wait_limit) begin
      @(negedge clock);
      #1;
      n++;
    end
    if (!(s_awready && s_wready)) begin
      note_timeout("awready and wready");
    end
    @(negedge clock);
    s_awvalid = 1'b0;
    s_wvalid = 1'b0;
    n = 0;
    while (!s_bvalid && n < wait_limit) begin
      @(negedge clock);
      n++;
    end
    if (!s_bvalid) begin
      note_timeout("bvalid");
    end
    resp = s_bresp;
  endtask

  task automatic axi_read(input logic [addr_width-1:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    s_araddr = addr;
    s_arvalid = 1'b1;
    n = 0;
    #1;
    while (!s_arready && n < wait_limit) begin
      @(negedge clock);
      #1;
      n++;
    end
    if (!s_arready) begin
      note_timeout("arready");
    end
    @(negedge clock);
    s_arvalid = 1'b0;
    n = 0;
    while (!s_rvalid && n < wait_limit) begin
      @(negedge clock);
      n++;
    end
    if (!s_rvalid) begin
      note_timeout("rvalid");
    end
    data = s_rdata;
    resp = s_rresp;
  endtask

  task automatic write_reg(input uart_reg_e op, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(offset_of(op), data, resp);
    check_resp("bresp", resp, resp_okay);
    model_write(op, data);
  endtask

  task automatic read_expect(input uart_reg_e op);
    logic [31:0] data;
    logic [1:0] resp;
    axi_read(offset_of(op), data, resp);
    check_resp("rresp", resp, resp_okay);
    check_data($sformatf("rdata of %s", op.name()), data, exp_read(op, model));
  endtask

  // Pops one byte that the model already counts in the receive FIFO
  task automatic pop_expect();
    model.rx_head = (sent_q.size() > 0) ? sent_q[0] : 8'd0;
    read_expect(reg_rxdata);
    if (model.rx_level != '0) begin
      model.rx_level = model.rx_level - level_width'(1);
      void'(sent_q.pop_front());
    end
  endtask

  task automatic wait_rx_byte();
    logic [31:0] data;
    logic [1:0] resp;
    int n;
    n = 0;
    data = 32'h8000_0000;
    while (data[31] && n < poll_limit) begin
      axi_read(offset_of(reg_rxdata), data, resp);
      n++;
    end
    if (data[31]) begin
      note_timeout("a byte in the receive FIFO");
    end else begin
      model.rx_level = level_width'(1);
      model.rx_head = (sent_q.size() > 0) ? sent_q[0] : 8'd0;
      check_resp("rresp", resp, resp_okay);
      check_data("rdata of reg_rxdata", data, exp_read(reg_rxdata, model));
      model.rx_level = '0;
      if (sent_q.size() > 0) begin
        void'(sent_q.pop_front());
      end
    end
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (!irq && n < wait_limit) begin
      @(negedge clock);
      n++;
    end
    if (!irq) begin
      note_timeout("irq");
    end
  endtask

  initial begin
    logic [31:0] data;
    logic [1:0] resp;
    uart_reg_e rw_ops [4];
    void'($urandom(32'h769d_67f3));
    rw_ops = '{reg_txctrl, reg_rxctrl, reg_ie, reg_div};
    s_awaddr = '0;
    s_awvalid = 1'b0;
    s_wdata = 32'd0;
    s_wstrb = 4'h0;
    s_wvalid = 1'b0;
    s_bready = 1'b1;
    s_araddr = '0;
    s_arvalid = 1'b0;
    s_rready = 1'b1;
    apply_reset();

    // Reset values
    read_expect(reg_txctrl);
    read_expect(reg_rxctrl);
    read_expect(reg_ie);
    read_expect(reg_ip);
    read_expect(reg_div);
    read_expect(reg_rxdata);
    read_expect(reg_txdata);
    check_irq(exp_irq(model));

    foreach (rw_ops[i]) begin
      write_reg(rw_ops[i], $urandom);
      read_expect(rw_ops[i]);
    end
    read_expect(reg_ip);
    check_irq(exp_irq(model));

    // Unmapped and unaligned offsets
    foreach (bad_addr[i]) begin
      axi_write(bad_addr[i], $urandom, resp);
      check_resp("bresp", resp, resp_slverr);
      axi_read(bad_addr[i], data, resp);
      check_resp("rresp", resp, resp_slverr);
      check_data("rdata", data, 32'd0);
    end
    foreach (rw_ops[i]) begin
      read_expect(rw_ops[i]);
    end
    read_expect(reg_txdata);

    // Fill the transmit FIFO with the transmitter off
    write_reg(reg_ie, 32'd0);
    write_reg(reg_rxctrl, 32'd0);
    write_reg(reg_txctrl, 32'($urandom_range(7, 1)) << 16);
    repeat (9) begin
      write_reg(reg_txdata, $urandom_range(255, 0));
      read_expect(reg_txdata);
      read_expect(reg_ip);
    end
    check_irq(exp_irq(model));

    apply_reset();

    // Loopback
    write_reg(reg_div, 32'd3);
    write_reg(reg_rxctrl, 32'd1);
    write_reg(reg_txctrl, 32'd1);
    repeat (6) begin
      write_reg(reg_txdata, $urandom_range(255, 0));
    end
    repeat (6) begin
      wait_rx_byte();
    end
    read_expect(reg_rxdata);

    // Receive watermark above one entry
    write_reg(reg_rxctrl, 32'h0001_0001);
    write_reg(reg_ie, 32'd2);
    check_irq(exp_irq(model));
    write_reg(reg_txdata, $urandom_range(255, 0));
    write_reg(reg_txdata, $urandom_range(255, 0));
    wait_irq();
    model.tx_level = '0;
    model.rx_level = level_width'(2);
    read_expect(reg_ip);
    pop_expect();
    check_irq(exp_irq(model));
    pop_expect();
    check_irq(exp_irq(model));
    read_expect(reg_rxdata);

    $display("Checks done: %0d data errors, %0d response errors, %0d irq errors, %0d timeouts",
             data_errors, resp_errors, irq_errors, timeouts);
    if (data_errors + resp_errors + irq_errors + timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
source/uart_pkg.sv
source/uart_axil_front.sv
source/uart_reg_bank.sv
source/uart_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
tb/uart_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timescale 1ns/10ps --top-module uart_tb \
		-Mdir obj_dir -f all.f
	./obj_dir/Vuart_tb | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
